// ==== design/ChecksumPkg.sv ====
package ChecksumPkg;

    // one data word as stored in the block buffer
    localparam int WordW = 16;

    // checksum holds sum B over sum A
    localparam int SumW = 2 * WordW;

    // each half is reduced modulo 2^16 - 1
    localparam int FletcherMod = 65535;

    typedef logic [WordW-1:0] word_t;

    // upper half is sum B, lower half is sum A
    typedef logic [SumW-1:0] sum_t;

endpackage

// ==== design/BufferPkg.sv ====
package BufferPkg;

    // shared block buffer geometry
    localparam int BufDepth = 256;
    localparam int AddrW = $clog2(BufDepth);

    // one extra bit so a full-buffer block of 256 words fits
    localparam int LenW = AddrW + 1;

    // checksum channels sharing the buffer read port
    localparam int NumChannels = 2;
    localparam int ChanW = (NumChannels > 1) ? $clog2(NumChannels) : 1;

    typedef logic [AddrW-1:0] addr_t;
    typedef logic [LenW-1:0] len_t;
    typedef logic [ChanW-1:0] chanIdx_t;

endpackage

// ==== design/BufferReadIf.sv ====
interface BufferReadIf
    import ChecksumPkg::*, BufferPkg::*;
();

    // request side, held until grant
    logic req;
    addr_t addr;

    // same-cycle acceptance from the arbiter
    logic grant;

    // returned word, one cycle after grant
    logic rdValid;
    word_t rdData;

    modport requester (
        output req,
        output addr,
        input grant,
        input rdValid,
        input rdData
    );

    modport server (
        input req,
        input addr,
        output grant,
        output rdValid,
        output rdData
    );

endinterface

// ==== design/FletcherChecksum.sv ====
module FletcherChecksum
    import ChecksumPkg::*;
(
    input logic clk,
    input logic rst,
    input logic clear,
    input logic en,
    input word_t din,
    output sum_t dout
);

    // running sums, top bit only carries the trial addition
    logic [WordW:0] sumA;
    logic [WordW:0] sumB;

    // en delayed by one cycle for the B update
    logic enDly;

    // add and fold back into 0..FletcherMod-1 by one conditional subtract
    function automatic logic [WordW:0] addMod(input logic [WordW:0] x, input word_t y);
        logic [WordW:0] total;
        logic [WordW+1:0] trial;
        total = x + y;
        trial = {1'b0, total} - (WordW + 2)'(FletcherMod);
        // negative trial means total was already below the modulus
        return trial[WordW+1] ? total : trial[WordW:0];
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sumA <= '0;
            sumB <= '0;
            enDly <= 1'b0;
        end else begin
            enDly <= en;
            // sum A takes the new word at this edge
            if (en) begin
                sumA <= addMod(sumA, din);
            end
            // sum B takes the A that the previous word produced
            if (enDly) begin
                sumB <= addMod(sumB, sumA[WordW-1:0]);
            end
        end
    end

    // final two cycles after the last en
    assign dout = {sumB[WordW-1:0], sumA[WordW-1:0]};

endmodule

// ==== design/BlockBuffer.sv ====
module BlockBuffer
    import ChecksumPkg::*, BufferPkg::*;
(
    input logic clk,
    input logic wrEn,
    input addr_t wrAddr,
    input word_t wrData,
    input logic rdEn,
    input addr_t rdAddr,
    output word_t rdData
);

    // word storage, filled by the outside writer
    word_t mem [BufDepth];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read
    // data shows up the cycle after rdEn
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== design/ReadArbiter.sv ====
module ReadArbiter
    import ChecksumPkg::*, BufferPkg::*;
(
    input logic clk,
    input logic rst,
    BufferReadIf.server chans [NumChannels],
    output logic rdEn,
    output addr_t rdAddr,
    input word_t rdData
);

    // requests and addresses gathered from the interface array
    logic [NumChannels-1:0] reqVec;
    addr_t reqAddr [NumChannels];

    // one-hot grant of this cycle
    logic [NumChannels-1:0] grantVec;
    logic anyGrant;
    chanIdx_t winner;

    // channel with highest priority this cycle
    chanIdx_t ptr;

    // return path, one cycle behind the grant
    logic retValid;
    chanIdx_t retIdx;

    for (genvar i = 0; i < NumChannels; i++) begin : g_chan
        assign reqVec[i] = chans[i].req;
        assign reqAddr[i] = chans[i].addr;
        assign chans[i].grant = grantVec[i];
        // only the channel granted last cycle sees valid data
        assign chans[i].rdValid = retValid && (retIdx == chanIdx_t'(i));
        assign chans[i].rdData = rdData;
    end

    // search from ptr upward, wrapping at NumChannels
    always_comb begin
        int idx;
        grantVec = '0;
        anyGrant = 1'b0;
        winner = ptr;
        for (int off = 0; off < NumChannels; off++) begin
            idx = (int'(ptr) + off) % NumChannels;
            if (!anyGrant && reqVec[idx]) begin
                anyGrant = 1'b1;
                winner = chanIdx_t'(idx);
            end
        end
        if (anyGrant) begin
            grantVec[winner] = 1'b1;
        end
    end

    // winner drives the buffer read port
    assign rdEn = anyGrant;
    assign rdAddr = reqAddr[winner];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
            retValid <= 1'b0;
            retIdx <= '0;
        end else begin
            retValid <= anyGrant;
            retIdx <= winner;
            // rotate past the last winner
            if (anyGrant) begin
                ptr <= (int'(winner) == NumChannels - 1) ? '0 : chanIdx_t'(winner + 1'b1);
            end
        end
    end

endmodule

// ==== design/BlockChecksummer.sv ====
module BlockChecksummer
    import ChecksumPkg::*, BufferPkg::*;
(
    input logic clk,
    input logic rst,
    input logic start,
    input addr_t baseAddr,
    input len_t length,
    output logic busy,
    output logic done,
    output sum_t sum,
    BufferReadIf.requester mem
);

    // words still to be granted, and the address of the next one
    len_t reqLeft;
    addr_t nextAddr;

    // words still to come back from the buffer
    len_t retLeft;

    // start only counts while idle
    logic accept;

    assign accept = start && !busy;

    // request held until granted, next word right after
    assign mem.req = busy && (reqLeft != '0);
    assign mem.addr = nextAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            reqLeft <= '0;
            retLeft <= '0;
            nextAddr <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                nextAddr <= baseAddr;
                reqLeft <= length;
                retLeft <= length;
                // empty block finishes on the next cycle
                busy <= (length != '0);
                done <= (length == '0);
            end else if (busy) begin
                if (mem.grant) begin
                    nextAddr <= nextAddr + 1'b1;
                    reqLeft <= reqLeft - 1'b1;
                end
                if (mem.rdValid) begin
                    retLeft <= retLeft - 1'b1;
                end
                // all words in, one cycle spent on the B pipeline
                // done lands as the accumulator output settles
                if (retLeft == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // accumulator cleared on every accepted start
    FletcherChecksum u_fletcher (
        .clk(clk),
        .rst(rst),
        .clear(accept),
        .en(mem.rdValid),
        .din(mem.rdData),
        .dout(sum)
    );

endmodule

// ==== design/ChecksumTop.sv ====
module ChecksumTop
    import ChecksumPkg::*, BufferPkg::*;
(
    input logic clk,
    input logic rst,
    input logic wrEn,
    input addr_t wrAddr,
    input word_t wrData,
    input logic [NumChannels-1:0] start,
    input addr_t [NumChannels-1:0] baseAddr,
    input len_t [NumChannels-1:0] length,
    output logic [NumChannels-1:0] busy,
    output logic [NumChannels-1:0] done,
    output sum_t [NumChannels-1:0] sum
);

    // single buffer read port behind the arbiter
    logic bufRdEn;
    addr_t bufRdAddr;
    word_t bufRdData;

    // one read link per channel
    BufferReadIf readIf [NumChannels] ();

    BlockBuffer u_buffer (
        .clk(clk),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .rdEn(bufRdEn),
        .rdAddr(bufRdAddr),
        .rdData(bufRdData)
    );

    ReadArbiter u_arbiter (
        .clk(clk),
        .rst(rst),
        .chans(readIf),
        .rdEn(bufRdEn),
        .rdAddr(bufRdAddr),
        .rdData(bufRdData)
    );

    for (genvar i = 0; i < NumChannels; i++) begin : g_chan
        BlockChecksummer u_checksummer (
            .clk(clk),
            .rst(rst),
            .start(start[i]),
            .baseAddr(baseAddr[i]),
            .length(length[i]),
            .busy(busy[i]),
            .done(done[i]),
            .sum(sum[i]),
            .mem(readIf[i])
        );
    end

endmodule

// ==== test/ReadArbiter_props.sv ====
module ReadArbiterProps
    import BufferPkg::*;
(
    input logic clk,
    input logic rst,
    input logic [NumChannels-1:0] reqVec,
    input logic [NumChannels-1:0] grantVec
);

    // at most one grant per cycle
    assert property (@(posedge clk) disable iff (rst) $onehot0(grantVec))
        else $error("arbiter granted more than one channel");

    // grant only where a request is raised
    assert property (@(posedge clk) disable iff (rst) (grantVec & ~reqVec) == '0)
        else $error("arbiter granted a channel that was not requesting");

    for (genvar i = 0; i < NumChannels; i++) begin : g_fair
        // held request wins within one round of the pointer
        assert property (@(posedge clk) disable iff (rst)
            reqVec[i] |-> ##[0:NumChannels-1] grantVec[i])
            else $error("channel %0d request held too long without grant", i);
    end

endmodule

bind ReadArbiter ReadArbiterProps u_props (
    .clk(clk),
    .rst(rst),
    .reqVec(reqVec),
    .grantVec(grantVec)
);

// ==== test/ChecksumTb.sv ====
module ChecksumTb
    import ChecksumPkg::*, BufferPkg::*;
();

    // cycles allowed for one done wait
    localparam int DoneTimeout = 2000;

    logic clk;
    logic rst;
    logic wrEn;
    addr_t wrAddr;
    word_t wrData;
    logic [NumChannels-1:0] start;
    addr_t [NumChannels-1:0] baseAddr;
    len_t [NumChannels-1:0] length;
    logic [NumChannels-1:0] busy;
    logic [NumChannels-1:0] done;
    sum_t [NumChannels-1:0] sum;

    // shadow of the buffer contents
    word_t model [BufDepth];
    // sums captured in the done cycle
    sum_t gotSum [NumChannels];
    logic [31:0] lfsr;

    ChecksumTop u_dut (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .wrAddr(wrAddr),
        .wrData(wrData),
        .start(start),
        .baseAddr(baseAddr),
        .length(length),
        .busy(busy),
        .done(done),
        .sum(sum)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], stepLfsr()};
        end
        return value;
    endfunction

    // Fletcher-32 straight from the definition, mod 65535 on each step
    function automatic sum_t modelSum(input addr_t base, input len_t len);
        int a;
        int b;
        a = 0;
        b = 0;
        for (int i = 0; i < int'(len); i++) begin
            a = (a + int'(model[addr_t'(int'(base) + i)])) % FletcherMod;
            b = (b + a) % FletcherMod;
        end
        return {b[WordW-1:0], a[WordW-1:0]};
    endfunction

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h got %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic fillWords(input addr_t base, input int n, input logic useRand,
                             input word_t value);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            wrEn = 1'b1;
            wrAddr = addr_t'(int'(base) + i);
            wrData = useRand ? word_t'(randBits(WordW)) : value;
            model[wrAddr] = wrData;
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    // one-cycle start on the masked channels
    task automatic launch(input logic [NumChannels-1:0] mask);
        @(negedge clk);
        start = mask;
        @(negedge clk);
        start = '0;
    endtask

    // done is a one-cycle pulse, so every channel is watched each cycle
    task automatic waitDone(input logic [NumChannels-1:0] mask);
        logic [NumChannels-1:0] seen;
        int cycles;
        int missing;
        seen = '0;
        cycles = 0;
        missing = 0;
        while ((seen & mask) != mask) begin
            for (int ch = 0; ch < NumChannels; ch++) begin
                if (mask[ch] && !seen[ch] && done[ch]) begin
                    seen[ch] = 1'b1;
                    gotSum[ch] = sum[ch];
                end
            end
            if ((seen & mask) != mask) begin
                if (cycles >= DoneTimeout) begin
                    for (int ch = NumChannels - 1; ch >= 0; ch--) begin
                        if (mask[ch] && !seen[ch]) begin
                            missing = ch;
                        end
                    end
                    $display("channel %0d done never arrived", missing);
                    abortRun();
                end
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // start, wait, compare with the model for the current base and length
    task automatic runAndCheck(input logic [NumChannels-1:0] mask);
        launch(mask);
        waitDone(mask);
        for (int ch = 0; ch < NumChannels; ch++) begin
            if (mask[ch]) begin
                checkEq($sformatf("sum[%0d]", ch), modelSum(baseAddr[ch], length[ch]),
                        gotSum[ch]);
                checkEq($sformatf("busy[%0d]", ch), 32'h0, busy[ch]);
            end
        end
    endtask

    initial begin
        lfsr = 32'h59f8;
        rst = 1'b1;
        wrEn = 1'b0;
        wrAddr = '0;
        wrData = '0;
        start = '0;
        baseAddr = '0;
        length = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // single channel on a fixed block
        fillWords(0, BufDepth, 1'b1, '0);
        baseAddr[0] = 8'd16;
        length[0] = 9'd200;
        runAndCheck(2'b01);

        // both channels at once, random blocks, wrapping allowed
        for (int trial = 0; trial < 4; trial++) begin
            fillWords(0, BufDepth, 1'b1, '0);
            for (int ch = 0; ch < NumChannels; ch++) begin
                baseAddr[ch] = addr_t'(randBits(AddrW));
                length[ch] = len_t'(randBits(AddrW)) + 1'b1;
            end
            runAndCheck(2'b11);
        end

        // all-ones words reduce to zero
        fillWords(0, BufDepth, 1'b0, 16'hFFFF);
        baseAddr[0] = '0;
        length[0] = 9'd256;
        runAndCheck(2'b01);
        checkEq("sum[0] A half below FFFF", 32'h1, gotSum[0][15:0] != 16'hFFFF);
        checkEq("sum[0] B half below FFFF", 32'h1, gotSum[0][31:16] != 16'hFFFF);

        // 0xFFFE words, both channels overlapping
        fillWords(0, BufDepth, 1'b0, 16'hFFFE);
        baseAddr[1] = 8'd100;
        length[1] = 9'd77;
        runAndCheck(2'b11);
        for (int ch = 0; ch < NumChannels; ch++) begin
            checkEq($sformatf("sum[%0d] A half below FFFF", ch), 32'h1,
                    gotSum[ch][15:0] != 16'hFFFF);
            checkEq($sformatf("sum[%0d] B half below FFFF", ch), 32'h1,
                    gotSum[ch][31:16] != 16'hFFFF);
        end

        // empty block
        baseAddr[1] = 8'd5;
        length[1] = '0;
        runAndCheck(2'b10);
        checkEq("sum[1]", 32'h0, gotSum[1]);

        // second start while busy must not disturb the first block
        fillWords(0, BufDepth, 1'b1, '0);
        baseAddr[0] = 8'd10;
        length[0] = 9'd120;
        launch(2'b01);
        repeat (5) @(negedge clk);
        baseAddr[0] = 8'd200;
        length[0] = 9'd30;
        launch(2'b01);
        waitDone(2'b01);
        checkEq("sum[0]", modelSum(8'd10, 9'd120), gotSum[0]);

        // reset in the middle of a long run on both channels
        baseAddr[0] = '0;
        length[0] = 9'd256;
        baseAddr[1] = 8'd40;
        length[1] = 9'd200;
        launch(2'b11);
        repeat (20) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        checkEq("busy", 32'h0, busy);
        checkEq("done", 32'h0, done);
        checkEq("sum[0]", 32'h0, sum[0]);
        checkEq("sum[1]", 32'h0, sum[1]);
        rst = 1'b0;
        baseAddr[1] = 8'd30;
        length[1] = 9'd90;
        runAndCheck(2'b11);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
design/ChecksumPkg.sv
design/BufferPkg.sv
design/BufferReadIf.sv
design/FletcherChecksum.sv
design/BlockBuffer.sv
design/ReadArbiter.sv
design/BlockChecksummer.sv
design/ChecksumTop.sv
test/ReadArbiter_props.sv
test/ChecksumTb.sv
